/* filelist.f */
hw/board_pkg.sv
hw/mic_i2s_receiver.sv
hw/audio_i2s_transmitter.sv
hw/seg7_scanner.sv
hw/lab_top.sv
hw/board_top.sv
testbench/tb_board_top.sv

/* hw/audio_i2s_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_i2s_transmitter
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_sound - 1:0] sound,           // Level, captured once per frame
    output aud_pins_t            pins
);

    // ------------------------------------------------------------------------
    // Clock generation

    logic                    mclk_q;              // clk divided by 2
    logic [aud_half_w - 1:0] half_cnt;
    logic                    bclk_q;
    logic                    lrclk_q;
    logic                    sdata_q;
    logic [aud_bit_w - 1:0]  bit_cnt;             // Bit clock index inside the frame
    logic [aud_bit_w - 1:0]  bit_nxt;
    logic                    half_last;
    logic                    bclk_fall;
    logic                    left_start;          // Falling edge opening the left slot
    logic                    right_start;         // Falling edge opening the right slot
    logic [w_sound - 1:0]    word_q;              // Word sent in both slots
    logic [w_sound - 1:0]    shift_q;             // Outgoing bits, MSB first

    assign half_last   = (half_cnt == aud_bclk_half - 1);
    assign bclk_fall   = half_last && bclk_q;
    assign bit_nxt     = (bit_cnt == aud_frame_bits - 1) ? '0 : bit_cnt + 1'b1;
    assign left_start  = bclk_fall && (bit_nxt == '0);
    assign right_start = bclk_fall && (bit_nxt == aud_slot_bits);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk_q   <= 1'b0;
            half_cnt <= '0;
            bclk_q   <= 1'b0;
            bit_cnt  <= aud_bit_w'(aud_frame_bits - 1);  // First fall opens a left slot
            lrclk_q  <= 1'b0;
            sdata_q  <= 1'b0;
        end
        else
        begin
            mclk_q   <= ~mclk_q;
            half_cnt <= half_last ? '0 : half_cnt + 1'b1;
            if (half_last)
                bclk_q <= ~bclk_q;
            if (bclk_fall)
            begin
                bit_cnt <= bit_nxt;
                lrclk_q <= (bit_nxt >= aud_slot_bits);
                // Slot edge carries a zero, MSB follows one bit clock later
                sdata_q <= (left_start || right_start) ? 1'b0 : shift_q[w_sound - 1];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Payload shifter, zeros fill in after the 16 data bits

    always_ff @(posedge clk)
    begin
        if (left_start)
        begin
            word_q  <= sound;
            shift_q <= sound;
        end
        else if (right_start)
            shift_q <= word_q;                    // Same word again for the right slot
        else if (bclk_fall)
            shift_q <= shift_q << 1;
    end

    assign pins = '{mclk: mclk_q, bclk: bclk_q, lrclk: lrclk_q, sdata: sdata_q};

    a_sdata_on_bclk_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(sdata_q) |-> $fell(bclk_q));

endmodule

`default_nettype wire

/* hw/board_pkg.sv */
`default_nettype none

package board_pkg;

    // ------------------------------------------------------------------------
    // Board widths

    localparam int w_key   = 2;                   // Push buttons
    localparam int w_sw    = 10;                  // Slide switches
    localparam int w_led   = 10;                  // Red LEDs in the bar
    localparam int w_digit = 6;                   // Static seven-segment digits
    localparam int w_mic   = 24;                  // Microphone sample
    localparam int w_sound = 16;                  // DAC sample

    // ------------------------------------------------------------------------
    // Serial audio and scan timing, kept small for quick simulation

    localparam int mic_sck_half   = 4;            // clk cycles per sck half period
    localparam int mic_slot_bits  = 32;           // Bit clocks per channel
    localparam int mic_frame_bits = 2 * mic_slot_bits;

    localparam int aud_bclk_half  = 4;            // clk cycles per bclk half period
    localparam int aud_slot_bits  = 32;           // Bit clocks per channel
    localparam int aud_frame_bits = 2 * aud_slot_bits;

    localparam int scan_period    = 16;           // clk cycles per digit step

    // Counter widths derived from the timing above
    localparam int mic_half_w = $clog2(mic_sck_half);
    localparam int mic_bit_w  = $clog2(mic_frame_bits);
    localparam int aud_half_w = $clog2(aud_bclk_half);
    localparam int aud_bit_w  = $clog2(aud_frame_bits);
    localparam int scan_w     = $clog2(scan_period);

    // ------------------------------------------------------------------------
    // Shared bundles

    typedef struct packed {
        logic                      valid;         // One clk strobe per frame
        logic signed [w_mic - 1:0] value;         // Left channel, two's complement
    } mic_sample_t;

    typedef struct packed {
        logic [7:0]           abcdefgh;           // Segment a in MSB, h is the point
        logic [w_digit - 1:0] digit;              // One-hot digit select
    } seg_drive_t;

    typedef struct packed {
        logic ws;                                 // Low selects the left slot
        logic sck;
    } mic_pins_t;

    typedef struct packed {
        logic mclk;
        logic bclk;
        logic lrclk;                              // Low during the left slot
        logic sdata;
    } aud_pins_t;

endpackage

`default_nettype wire

/* hw/board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_top
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [w_key - 1:0]   key,
    input  logic [w_sw - 2:0]    sw,
    output logic [w_led - 1:0]   ledr,

    output logic [7:0]           hex0,            // Active low, segment a in bit 0
    output logic [7:0]           hex1,
    output logic [7:0]           hex2,
    output logic [7:0]           hex3,
    output logic [7:0]           hex4,
    output logic [7:0]           hex5,

    input  logic                 mic_sd,          // I2S MEMS microphone
    output logic                 mic_lr,
    output logic                 mic_ws,
    output logic                 mic_sck,

    output logic                 aud_mclk,        // I2S audio DAC
    output logic                 aud_bclk,
    output logic                 aud_lrclk,
    output logic                 aud_sdata
);

    mic_sample_t          mic_sample;
    mic_pins_t            mic_pins;
    aud_pins_t            aud_pins;
    seg_drive_t           seg;
    logic [w_mic - 1:0]   display_word;
    logic [w_sound - 1:0] sound;
    logic [7:0]           hgfedcba;               // Segment a moved to bit 0
    logic [7:0]           hex_q [w_digit];        // Sticky per-digit patterns

    // ------------------------------------------------------------------------
    // Datapath blocks around the lab core

    mic_i2s_receiver i_mic (
        .clk    (clk),
        .rst    (rst),
        .sd     (mic_sd),
        .pins   (mic_pins),
        .sample (mic_sample)
    );

    lab_top i_lab (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .sw           (sw),
        .sample       (mic_sample),
        .ledr         (ledr),
        .display_word (display_word),
        .sound        (sound)
    );

    seg7_scanner i_scan (
        .clk  (clk),
        .rst  (rst),
        .word (display_word),
        .seg  (seg)
    );

    audio_i2s_transmitter i_dac (
        .clk   (clk),
        .rst   (rst),
        .sound (sound),
        .pins  (aud_pins)
    );

    // ------------------------------------------------------------------------
    // Pin mapping

    assign mic_lr    = 1'b0;                      // Microphone answers in the left slot
    assign mic_ws    = mic_pins.ws;
    assign mic_sck   = mic_pins.sck;

    assign aud_mclk  = aud_pins.mclk;
    assign aud_bclk  = aud_pins.bclk;
    assign aud_lrclk = aud_pins.lrclk;
    assign aud_sdata = aud_pins.sdata;

    // ------------------------------------------------------------------------
    // Static display from the scanned bus

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = seg.abcdefgh[7 - i];
    end

    // Each digit keeps its last pattern between visits, so no flicker
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < w_digit; i++)
                hex_q[i] <= '1;                   // All segments dark
        end
        else
        begin
            for (int i = 0; i < w_digit; i++)
                if (seg.digit[i])
                    hex_q[i] <= ~hgfedcba;
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

`default_nettype wire

/* hw/lab_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lab_top
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_key - 1:0]   key,             // key[0] holds the display
    input  logic [w_sw - 2:0]    sw,              // sw[0] enables the loopback
    input  mic_sample_t          sample,
    output logic [w_led - 1:0]   ledr,            // Level bar
    output logic [w_mic - 1:0]   display_word,
    output logic [w_sound - 1:0] sound
);

    // ------------------------------------------------------------------------
    // Level bar

    // Magnitude saturated to 23 bits, then one LED per bit from bit 13 up
    function automatic logic [w_led - 1:0] level_bar(input logic [w_mic - 1:0] v);
        logic [w_mic - 1:0] mag;
        logic [w_mic - 2:0] m;
        logic [w_led - 1:0] bar;
        mag = v[w_mic - 1] ? (~v + 1'b1) : v;
        m   = mag[w_mic - 1] ? '1 : mag[w_mic - 2:0];  // Most negative value clips
        for (int i = 0; i < w_led; i++)
            bar[i] = |(m >> (w_mic - 1 - w_led + i));
        return bar;
    endfunction

    // ------------------------------------------------------------------------
    // Sample, bar and display registers

    logic [w_mic - 1:0] sample_q;                 // Latest sample
    logic [w_mic - 1:0] disp_q;                   // Word on the digits
    logic [w_led - 1:0] ledr_q;
    logic               hold;

    assign hold = key[0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample_q <= '0;
            disp_q   <= '0;
            ledr_q   <= '0;
        end
        else
        begin
            if (sample.valid)
            begin
                sample_q <= sample.value;
                ledr_q   <= level_bar(sample.value);  // Bar runs during hold too
            end
            // Frozen while held, catches up with the latest sample on release
            if (!hold)
                disp_q <= sample.valid ? sample.value : sample_q;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs

    assign ledr         = ledr_q;
    assign display_word = disp_q;
    assign sound        = sw[0] ? sample_q[w_mic - 1 -: w_sound] : '0;  // Top 16 bits

    a_ledr_thermometer: assert property (@(posedge clk) disable iff (rst)
        ((ledr + 1'b1) & ledr) == '0);

endmodule

`default_nettype wire

/* hw/mic_i2s_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_i2s_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,                       // Serial data from the microphone
    output mic_pins_t   pins,
    output mic_sample_t sample
);

    // ------------------------------------------------------------------------
    // Bit clock and frame position

    logic [mic_half_w - 1:0] half_cnt;            // Position inside sck half period
    logic                    sck_q;
    logic                    ws_q;
    logic [mic_bit_w - 1:0]  bit_cnt;             // Bit clock index inside the frame
    logic [mic_bit_w - 1:0]  bit_nxt;
    logic                    half_last;
    logic                    sck_rise;
    logic                    sck_fall;
    logic                    take_bit;            // Rising edge inside the data window
    logic                    valid_q;
    logic [w_mic - 1:0]      shift_q;             // Sample assembly, MSB first

    assign half_last = (half_cnt == mic_sck_half - 1);
    assign sck_rise  = half_last && !sck_q;
    assign sck_fall  = half_last &&  sck_q;

    // Frame counter advances on each falling edge and wraps at the frame end
    assign bit_nxt = (bit_cnt == mic_frame_bits - 1) ? '0 : bit_cnt + 1'b1;

    // MSB appears one bit clock after ws falls, so bits land in slots 1 to 24
    assign take_bit = sck_rise && (bit_cnt >= 1) && (bit_cnt <= w_mic);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            half_cnt <= '0;
            sck_q    <= 1'b0;
            ws_q     <= 1'b0;                     // Start in the left slot
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end
        else
        begin
            half_cnt <= half_last ? '0 : half_cnt + 1'b1;
            if (half_last)
                sck_q <= ~sck_q;
            if (sck_fall)
            begin
                bit_cnt <= bit_nxt;
                ws_q    <= (bit_nxt >= mic_slot_bits);  // Right slot in upper half
            end
            valid_q <= take_bit && (bit_cnt == w_mic);  // Strobe after the LSB
        end
    end

    // ------------------------------------------------------------------------
    // Sample shift register

    always_ff @(posedge clk)
    begin
        if (take_bit)
            shift_q <= {shift_q[w_mic - 2:0], sd};
    end

    assign pins   = '{ws: ws_q, sck: sck_q};
    assign sample = '{valid: valid_q, value: shift_q};

    // Strobe only while the frame position still sits on the LSB of the left slot
    a_valid_after_lsb: assert property (@(posedge clk) disable iff (rst)
        valid_q |-> !ws_q && (bit_cnt == w_mic));

endmodule

`default_nettype wire

/* hw/seg7_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_scanner
    import board_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4 * w_digit - 1:0] word,        // Six hex nibbles, digit 0 is low
    output seg_drive_t               seg
);

    logic [scan_w - 1:0]  scan_cnt;               // Cycles spent on the current digit
    logic                 step;
    logic [w_digit - 1:0] sel;                    // One-hot rotator
    logic [3:0]           nibble;
    seg_drive_t           seg_q;

    // Hex to segments, a in bit 7, point always dark
    function automatic logic [7:0] hex_to_seg(input logic [3:0] h);
        logic [7:0] s;
        case (h)
            4'h0:    s = 8'b1111_1100;
            4'h1:    s = 8'b0110_0000;
            4'h2:    s = 8'b1101_1010;
            4'h3:    s = 8'b1111_0010;
            4'h4:    s = 8'b0110_0110;
            4'h5:    s = 8'b1011_0110;
            4'h6:    s = 8'b1011_1110;
            4'h7:    s = 8'b1110_0000;
            4'h8:    s = 8'b1111_1110;
            4'h9:    s = 8'b1111_0110;
            4'ha:    s = 8'b1110_1110;
            4'hb:    s = 8'b0011_1110;
            4'hc:    s = 8'b1001_1100;
            4'hd:    s = 8'b0111_1010;
            4'he:    s = 8'b1001_1110;
            default: s = 8'b1000_1110;            // F
        endcase
        return s;
    endfunction

    assign step = (scan_cnt == scan_period - 1);

    // Nibble of the digit currently selected
    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < w_digit; i++)
            if (sel[i])
                nibble |= word[4 * i +: 4];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            sel      <= w_digit'(1);              // Digit 0 first
            seg_q    <= '{abcdefgh: '0, digit: w_digit'(1)};
        end
        else
        begin
            scan_cnt <= step ? '0 : scan_cnt + 1'b1;
            if (step)
                sel <= {sel[w_digit - 2:0], sel[w_digit - 1]};  // Walk up and wrap
            // Segments and select registered together so they never disagree
            seg_q.abcdefgh <= hex_to_seg(nibble);
            seg_q.digit    <= sel;
        end
    end

    assign seg = seg_q;

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(seg_q.digit) && $onehot(sel));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the board_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top -f filelist.f -o tb_board_top

./obj_dir/tb_board_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

/* testbench/tb_board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_board_top
    import board_pkg::*;
();

    localparam int mic_frame_clks = 2 * mic_sck_half * mic_frame_bits;   // clk per mic frame
    localparam int aud_frame_clks = 2 * aud_bclk_half * aud_frame_bits;  // clk per DAC frame
    localparam int settle_clks    = 7 * scan_period + 4;                 // All digits revisited

    logic                 clk;
    logic                 rst;
    logic [w_key - 1:0]   key;
    logic [w_sw - 2:0]    sw;
    logic [w_led - 1:0]   ledr;
    logic [7:0]           hex_out [w_digit];
    logic                 mic_sd;
    logic                 mic_lr;
    logic                 mic_ws;
    logic                 mic_sck;
    logic                 aud_mclk;
    logic                 aud_bclk;
    logic                 aud_lrclk;
    logic                 aud_sdata;

    logic [31:0]          lfsr_state;              // Random source
    logic [w_mic - 1:0]   mic_next;                // Word queued by the test
    int                   next_tag;
    logic [w_mic - 1:0]   mic_cur;                 // Word of the current mic frame
    int                   cur_tag;
    int                   done_tag;                // Last word fully shifted out
    int                   mic_pos;                 // sck falls since ws fell
    logic                 mic_prev_sck;
    logic                 mic_prev_ws;
    logic                 mic_fell;
    logic                 mic_bit;

    int                   dac_pos;                 // bclk rises since lrclk edge
    logic                 dac_prev_bclk;
    logic                 dac_prev_lr;
    logic [w_sound - 1:0] dac_shift;
    logic [w_sound - 1:0] dac_left;
    logic [w_sound - 1:0] dac_right;
    logic                 dac_have_left;
    int                   dac_frames;              // Completed left plus right pairs

    board_top UUT (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .sw        (sw),
        .ledr      (ledr),
        .hex0      (hex_out[0]),
        .hex1      (hex_out[1]),
        .hex2      (hex_out[2]),
        .hex3      (hex_out[3]),
        .hex4      (hex_out[4]),
        .hex5      (hex_out[5]),
        .mic_sd    (mic_sd),
        .mic_lr    (mic_lr),
        .mic_ws    (mic_ws),
        .mic_sck   (mic_sck),
        .aud_mclk  (aud_mclk),
        .aud_bclk  (aud_bclk),
        .aud_lrclk (aud_lrclk),
        .aud_sdata (aud_sdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // 4 ns period
    end

    // ------------------------------------------------------------------------
    // Reference models

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Board order table, a in bit 0, then point dark and active low
    function automatic logic [7:0] hex_ref(input logic [3:0] n);
        logic [6:0] gfedcba;
        case (n)
            4'h0:    gfedcba = 7'h3f;
            4'h1:    gfedcba = 7'h06;
            4'h2:    gfedcba = 7'h5b;
            4'h3:    gfedcba = 7'h4f;
            4'h4:    gfedcba = 7'h66;
            4'h5:    gfedcba = 7'h6d;
            4'h6:    gfedcba = 7'h7d;
            4'h7:    gfedcba = 7'h07;
            4'h8:    gfedcba = 7'h7f;
            4'h9:    gfedcba = 7'h6f;
            4'ha:    gfedcba = 7'h77;
            4'hb:    gfedcba = 7'h7c;
            4'hc:    gfedcba = 7'h39;
            4'hd:    gfedcba = 7'h5e;
            4'he:    gfedcba = 7'h79;
            default: gfedcba = 7'h71;
        endcase
        return ~{1'b0, gfedcba};
    endfunction

    function automatic logic [w_led - 1:0] bar_ref(input logic [w_mic - 1:0] v);
        longint             mag;
        logic [w_led - 1:0] bar;
        mag = longint'(v);                         // Zero extended
        if (v[w_mic - 1])
            mag = (longint'(1) << w_mic) - mag;    // Absolute value of a negative word
        if (mag > 64'h7f_ffff)
            mag = 64'h7f_ffff;                     // Saturate to 23 bits
        for (int i = 0; i < w_led; i++)
            bar[i] = (mag >> (13 + i)) != 0;
        return bar;
    endfunction

    function automatic logic [w_sound - 1:0] dac_ref(input logic [w_mic - 1:0] v,
                                                     input logic loop_on);
        return loop_on ? v[23:8] : '0;
    endfunction

    // ------------------------------------------------------------------------
    // Microphone model, new bit after each falling sck

    always @(posedge clk)
    begin
        if (rst)
        begin
            mic_pos      = 0;
            mic_prev_sck = 1'b0;
            mic_prev_ws  = 1'b0;
            mic_cur      = mic_next;
            cur_tag      = next_tag;
        end
        else
        begin
            mic_fell = mic_prev_sck && !mic_sck;
            if (mic_fell)
            begin
                if (mic_prev_ws && !mic_ws)
                    mic_pos = 0;                   // Left slot opens
                else
                    mic_pos = mic_pos + 1;
                if (mic_pos == 0)
                begin
                    mic_cur = mic_next;            // Pick up the queued word
                    cur_tag = next_tag;
                end
                if (mic_pos == w_mic + 1)
                    done_tag = cur_tag;            // LSB already taken by the DUT
                mic_bit = (mic_pos >= 1 && mic_pos <= w_mic) ? mic_cur[w_mic - mic_pos] : 1'b0;
            end
            mic_prev_sck = mic_sck;
            mic_prev_ws  = mic_ws;
            if (mic_fell)
                #1 mic_sd = mic_bit;
        end
    end

    // ------------------------------------------------------------------------
    // DAC capture on rising bclk

    always @(posedge clk)
    begin
        if (rst)
        begin
            dac_pos       = 63;                    // No capture until an lrclk edge
            dac_prev_bclk = 1'b0;
            dac_prev_lr   = 1'b0;
            dac_have_left = 1'b0;
        end
        else
        begin
            if (aud_bclk && !dac_prev_bclk)
            begin
                if (aud_lrclk != dac_prev_lr)
                    dac_pos = 0;
                else if (dac_pos < 63)
                    dac_pos = dac_pos + 1;
                dac_prev_lr = aud_lrclk;
                if (dac_pos >= 1 && dac_pos <= w_sound)
                    dac_shift = {dac_shift[w_sound - 2:0], aud_sdata};
                if (dac_pos == w_sound && !aud_lrclk)
                begin
                    dac_left      = dac_shift;
                    dac_have_left = 1'b1;
                end
                else if (dac_pos == w_sound && dac_have_left)
                begin
                    dac_right  = dac_shift;
                    dac_frames = dac_frames + 1;   // Both slots of one frame seen
                end
            end
            dac_prev_bclk = aud_bclk;
        end
    end

    // ------------------------------------------------------------------------
    // Test helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s never came", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic draw_random_word(output logic [w_mic - 1:0] w);
        w = '0;
        for (int i = 0; i < w_mic; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);    // One step per bit
            w = {w[w_mic - 2:0], lfsr_state[0]};
        end
    endtask

    // Queue a word and wait until the microphone has shifted all of it out
    task automatic send_sample(input logic [w_mic - 1:0] w);
        int waited;
        mic_next = w;
        next_tag = next_tag + 1;
        waited   = 0;
        while (done_tag != next_tag && waited < 3 * mic_frame_clks)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (done_tag != next_tag)
            report_timeout("end of microphone frame");
    endtask

    task automatic wait_dac_frames(input int n);
        int start;
        int waited;
        start  = dac_frames;
        waited = 0;
        while (dac_frames < start + n && waited < (n + 2) * aud_frame_clks)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (dac_frames < start + n)
            report_timeout("DAC frame");
    endtask

    task automatic check_hex(input string name, input logic [w_mic - 1:0] w);
        for (int i = 0; i < w_digit; i++)
            check_value($sformatf("%s hex%0d", name, i), hex_ref(w[4 * i +: 4]), hex_out[i]);
    endtask

    task automatic run_sample(input string name, input logic [w_mic - 1:0] w);
        send_sample(w);
        wait_cycles(2);
        check_value({name, " ledr"}, bar_ref(w), ledr);
        wait_cycles(settle_clks);
        check_hex(name, w);
        wait_dac_frames(2);                        // Second frame starts after the update
        check_value({name, " dac left"}, dac_ref(w, sw[0]), dac_left);
        check_value({name, " dac right"}, dac_ref(w, sw[0]), dac_right);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence

    initial
    begin
        logic [w_mic - 1:0] w;
        rst        = 1'b1;
        key        = '0;
        sw         = '0;
        mic_sd     = 1'b0;
        mic_next   = '0;
        next_tag   = 0;
        done_tag   = 0;
        dac_frames = 0;
        lfsr_state = 32'h0a6c_f5f6;

        wait_cycles(10);
        for (int i = 0; i < w_digit; i++)
            check_value($sformatf("reset hex%0d", i), 8'hff, hex_out[i]);
        check_value("reset ledr", '0, ledr);
        check_value("reset aud_sdata", 1'b0, aud_sdata);
        check_value("reset mic_lr", 1'b0, mic_lr);
        check_value("reset mic_ws", 1'b0, mic_ws);
        check_value("reset mic_sck", 1'b0, mic_sck);
        check_value("reset aud_mclk", 1'b0, aud_mclk);
        check_value("reset aud_bclk", 1'b0, aud_bclk);
        check_value("reset aud_lrclk", 1'b0, aud_lrclk);
        rst = 1'b0;

        // Master clock is clk divided by 2, high after the first edge out of reset
        for (int i = 1; i <= 4; i++)
        begin
            wait_cycles(1);
            check_value("aud_mclk divide", i % 2, aud_mclk);
        end

        sw = 9'h001;                               // Loopback on
        for (int n = 0; n < 6; n++)
        begin
            draw_random_word(w);
            run_sample("random loopback", w);
        end
        run_sample("most negative", 24'h80_0000);
        run_sample("most positive", 24'h7f_ffff);
        run_sample("plus one", 24'h00_0001);
        run_sample("minus one", 24'hff_ffff);
        run_sample("first bar step", 24'h00_2000);
        run_sample("first bar step negative", 24'hff_e000);

        sw = 9'h000;                               // Loopback off
        for (int n = 0; n < 2; n++)
        begin
            draw_random_word(w);
            run_sample("random muted", w);
        end

        // Display hold on key[0]
        run_sample("before hold", 24'h13_579b);
        key = 2'b01;
        send_sample(24'hfd_b864);
        wait_cycles(2);
        check_value("held ledr", bar_ref(24'hfd_b864), ledr);
        wait_cycles(settle_clks);
        check_hex("held", 24'h13_579b);
        key = 2'b00;
        wait_cycles(settle_clks);
        check_hex("released", 24'hfd_b864);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
